// File: filelist.f
+incdir+rtl
+incdir+dv
rtl/gfx_pkg.sv
rtl/scan_if.sv
rtl/render_cfg_if.sv
rtl/display_timing.sv
rtl/host_regs.sv
rtl/pixel_renderer.sv
rtl/gfx_core.sv
dv/gfx_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the gfx_core testbench with Verilator, run it and scan the log

rm -f sim.log
verilator --binary --timing -f filelist.f --top-module gfx_core_tb -o gfx_core_tb_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/gfx_core_tb_sim > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// File: dv/gfx_ref.svh
// Reference model for the display controller testbench
// Register and palette image updates, expected read data, sync levels and pixel colour
`ifndef GFX_REF_SVH
`define GFX_REF_SVH

// Phase of a scan position on one axis
function automatic scan_phase_e phase_of(input int pos, input int vis, input int front,
                                         input int sync);
  if (pos < vis) return PH_VISIBLE;
  if (pos < vis + front) return PH_FRONT;
  if (pos < vis + front + sync) return PH_SYNC;
  return PH_BACK;
endfunction

// Bytes follow the enables while ID, status and unused indices keep their value
task automatic model_write(input logic [`GFX_ADDR_W-1:0] addr,
                           input logic [`GFX_DATA_W-1:0] data, input logic [1:0] be);
  int roff;
  int poff;
  roff = int'(addr) - `GFX_REG_BASE;
  poff = int'(addr) - `GFX_PAL_BASE;
  if (roff >= REG_CTRL && roff <= REG_RECT_INDEX) begin
    if (be[0]) reg_img[roff][7:0] = data[7:0];
    if (be[1]) reg_img[roff][15:8] = data[15:8];
  end else if (poff >= 0 && poff < `GFX_PAL_WORDS) begin
    if (poff % 2 == 0) begin
      if (be[0]) pal_img[poff / 2][7:0] = data[7:0];
      if (be[1]) pal_img[poff / 2][15:8] = data[15:8];
    end else if (be[0]) begin
      pal_img[poff / 2][17:16] = data[1:0];
    end
  end
endtask

// Status depends on the scan and is not modelled here
function automatic logic [`GFX_DATA_W-1:0] expected_read(input logic [`GFX_ADDR_W-1:0] addr);
  int roff;
  int poff;
  roff = int'(addr) - `GFX_REG_BASE;
  poff = int'(addr) - `GFX_PAL_BASE;
  if (roff >= 0 && roff < `GFX_NUM_REGS) begin
    if (roff == REG_ID) return `GFX_ID_VALUE;
    if (roff >= REG_CTRL && roff <= REG_RECT_INDEX) return reg_img[roff];
    return '0;
  end
  if (poff >= 0 && poff < `GFX_PAL_WORDS) begin
    if (poff % 2 == 0) return pal_img[poff / 2][15:0];
    return {14'b0, pal_img[poff / 2][17:16]};
  end
  return `GFX_UNMAPPED_VALUE;
endfunction

// Sync levels as {hsync, vsync}
function automatic logic [1:0] expected_sync(input int x, input int y);
  logic hs;
  logic vs;
  hs = (phase_of(x, `GFX_H_VISIBLE, `GFX_H_FRONT, `GFX_H_SYNC) == PH_SYNC) ?
       `GFX_SYNC_ACTIVE : ~`GFX_SYNC_ACTIVE;
  vs = (phase_of(y, `GFX_V_VISIBLE, `GFX_V_FRONT, `GFX_V_SYNC) == PH_SYNC) ?
       `GFX_SYNC_ACTIVE : ~`GFX_SYNC_ACTIVE;
  return {hs, vs};
endfunction

// Rectangle ends are exclusive and blanked or disabled pixels are black
function automatic logic [`GFX_RGB_W-1:0] expected_pixel(input int x, input int y);
  int rx;
  int ry;
  logic in_rect;
  if (!reg_img[REG_CTRL][0]) return '0;
  if (phase_of(x, `GFX_H_VISIBLE, `GFX_H_FRONT, `GFX_H_SYNC) != PH_VISIBLE) return '0;
  if (phase_of(y, `GFX_V_VISIBLE, `GFX_V_FRONT, `GFX_V_SYNC) != PH_VISIBLE) return '0;
  rx = int'(reg_img[REG_RECT_X]);
  ry = int'(reg_img[REG_RECT_Y]);
  in_rect = (x >= rx) && (x < rx + int'(reg_img[REG_RECT_W])) &&
            (y >= ry) && (y < ry + int'(reg_img[REG_RECT_H]));
  if (in_rect) return pal_img[reg_img[REG_RECT_INDEX][6:0]];
  return pal_img[reg_img[REG_BG_INDEX][6:0]];
endfunction

`endif

// File: dv/gfx_core_tb.sv
// Testbench for the display controller top level
// Clock, reset, bus tasks, scan tracker, checker processes and test sequence
`timescale 1ns/1ps
`include "gfx_cfg.svh"

module gfx_core_tb import gfx_pkg::*; ();

  localparam int H_TOTAL    = `GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK;
  localparam int V_TOTAL    = `GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK;
  localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;

  bit                     clk;
  logic                   rst;
  logic                   mpu_en;
  logic                   mpu_rd;
  logic                   mpu_wr;
  logic [1:0]             mpu_be;
  logic [`GFX_ADDR_W-1:0] mpu_addr;
  logic [`GFX_DATA_W-1:0] mpu_wdata;
  logic [`GFX_DATA_W-1:0] mpu_rdata;
  logic                   vga_hsync;
  logic                   vga_vsync;
  logic [`GFX_RGB_W-1:0]  vga_rgb;

  // Image of what the testbench wrote
  logic [`GFX_DATA_W-1:0] reg_img [`GFX_NUM_REGS];
  logic [`GFX_RGB_W-1:0]  pal_img [`GFX_PAL_ENTRIES];

  logic                   rd_req_q;
  logic [`GFX_DATA_W-1:0] rd_exp_q;
  logic                   prev_hsync;
  logic                   prev_vsync;
  logic                   h_lock;
  logic                   v_lock;
  int                     trk_x;
  int                     trk_y;
  logic                   frame_check;

  `include "gfx_ref.svh"

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  gfx_core i_gfx_core (
    .clk       (clk),
    .rst       (rst),
    .mpu_en    (mpu_en),
    .mpu_rd    (mpu_rd),
    .mpu_wr    (mpu_wr),
    .mpu_be    (mpu_be),
    .mpu_addr  (mpu_addr),
    .mpu_wdata (mpu_wdata),
    .mpu_rdata (mpu_rdata),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_rgb   (vga_rgb)
  );

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_rdata(input string name, input logic [`GFX_DATA_W-1:0] got,
                             input logic [`GFX_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_rgb(input string name, input logic [`GFX_RGB_W-1:0] got,
                           input logic [`GFX_RGB_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s at x %0d y %0d: got %h, expected %h", name, trk_x, trk_y, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_sync(input string name, input logic [1:0] got,
                            input logic [1:0] exp);
    if (got !== exp) begin
      $display("Fail %s at x %0d y %0d: got %h, expected %h", name, trk_x, trk_y, got, exp);
      stop_on_error();
    end
  endtask

  // Read data is due one clock after the request, zero otherwise
  always @(posedge clk) begin
    rd_req_q <= mpu_en && mpu_rd;
    rd_exp_q <= expected_read(mpu_addr);
  end

  always @(negedge clk) begin
    check_rdata("mpu_rdata", mpu_rdata, rd_req_q ? rd_exp_q : '0);
  end

  // Tracker locks on the first sync edges, then runs free
  always @(negedge clk) begin
    prev_hsync <= vga_hsync;
    prev_vsync <= vga_vsync;
    if (h_lock && v_lock) begin
      check_sync("vga_hsync,vga_vsync", {vga_hsync, vga_vsync}, expected_sync(trk_x, trk_y));
      if (frame_check) check_rgb("vga_rgb", vga_rgb, expected_pixel(trk_x, trk_y));
    end
    if (!h_lock && prev_hsync !== `GFX_SYNC_ACTIVE && vga_hsync === `GFX_SYNC_ACTIVE) begin
      trk_x  <= `GFX_H_VISIBLE + `GFX_H_FRONT + 1;
      h_lock <= 1'b1;
    end else begin
      trk_x <= (trk_x == H_TOTAL - 1) ? 0 : trk_x + 1;
    end
    // Vsync starts on the first pixel of its line
    if (!v_lock && prev_vsync !== `GFX_SYNC_ACTIVE && vga_vsync === `GFX_SYNC_ACTIVE) begin
      trk_y  <= `GFX_V_VISIBLE + `GFX_V_FRONT;
      v_lock <= 1'b1;
    end else if (trk_x == H_TOTAL - 1) begin
      trk_y <= (trk_y == V_TOTAL - 1) ? 0 : trk_y + 1;
    end
  end

  task automatic bus_idle();
    mpu_en    = 1'b0;
    mpu_rd    = 1'b0;
    mpu_wr    = 1'b0;
    mpu_be    = 2'b00;
    mpu_addr  = '0;
    mpu_wdata = '0;
  endtask

  task automatic write_word(input logic [`GFX_ADDR_W-1:0] addr,
                            input logic [`GFX_DATA_W-1:0] data, input logic [1:0] be);
    mpu_en    = 1'b1;
    mpu_wr    = 1'b1;
    mpu_addr  = addr;
    mpu_wdata = data;
    mpu_be    = be;
    model_write(addr, data, be);
    @(negedge clk);
    bus_idle();
  endtask

  task automatic read_word(input logic [`GFX_ADDR_W-1:0] addr);
    mpu_en   = 1'b1;
    mpu_rd   = 1'b1;
    mpu_addr = addr;
    @(negedge clk);
    bus_idle();
  endtask

  // Ends on the last pixel of a frame
  task automatic wait_frame_end();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 3 * FRAME_CLKS) begin
        $display("Timeout: the scan tracker never reached the end of a frame");
        stop_on_error();
      end
    end while (!(h_lock && v_lock && trk_x == H_TOTAL - 1 && trk_y == V_TOTAL - 1));
  endtask

  task automatic check_frame();
    frame_check <= 1'b1;
    repeat (FRAME_CLKS) @(negedge clk);
    frame_check <= 1'b0;
  endtask

  initial begin
    int bg;
    void'($urandom(32'hbfde));
    rst         = 1'b1;
    rd_req_q    <= 1'b0;
    rd_exp_q    <= '0;
    prev_hsync  <= ~`GFX_SYNC_ACTIVE;
    prev_vsync  <= ~`GFX_SYNC_ACTIVE;
    h_lock      <= 1'b0;
    v_lock      <= 1'b0;
    trk_x       <= 0;
    trk_y       <= 0;
    frame_check <= 1'b0;
    bus_idle();
    for (int i = 0; i < `GFX_NUM_REGS; i++) reg_img[i] = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // Idle outputs after reset, then the ID word
    check_rdata("mpu_rdata", mpu_rdata, '0);
    check_sync("vga_hsync,vga_vsync", {vga_hsync, vga_vsync},
               {~`GFX_SYNC_ACTIVE, ~`GFX_SYNC_ACTIVE});
    read_word(16'(`GFX_REG_BASE + REG_ID));

    // Register file with byte enables
    for (int i = 0; i < 40; i++) begin
      write_word(16'(`GFX_REG_BASE + 1 + $urandom % 7), 16'($urandom), 2'($urandom % 4));
    end
    write_word(16'(`GFX_REG_BASE + REG_ID), 16'($urandom), 2'b11);
    for (int i = 9; i < `GFX_NUM_REGS; i++) begin
      write_word(16'(`GFX_REG_BASE + i), 16'($urandom), 2'b11);
    end
    for (int i = 0; i < `GFX_NUM_REGS; i++) begin
      if (i != REG_STATUS) read_word(16'(`GFX_REG_BASE + i));
    end

    // Every palette word once, then partial updates
    for (int i = 0; i < `GFX_PAL_WORDS; i++) begin
      write_word(16'(`GFX_PAL_BASE + i), 16'($urandom), 2'b11);
    end
    for (int i = 0; i < 60; i++) begin
      write_word(16'(`GFX_PAL_BASE + $urandom % `GFX_PAL_WORDS), 16'($urandom), 2'($urandom % 4));
    end
    for (int i = 0; i < `GFX_PAL_WORDS; i++) read_word(16'(`GFX_PAL_BASE + i));
    for (int i = 0; i < 20; i++) begin
      if (i % 2 == 0) read_word(16'(16'h0010 + $urandom % 16'h00f0));
      else read_word(16'(16'h0200 + $urandom % 16'hfe00));
    end

    // One frame with a random rectangle
    bg = int'($urandom % `GFX_PAL_ENTRIES);
    write_word(16'(`GFX_REG_BASE + REG_BG_INDEX), 16'(bg), 2'b11);
    write_word(16'(`GFX_REG_BASE + REG_RECT_INDEX),
               16'((bg + 1 + $urandom % (`GFX_PAL_ENTRIES - 1)) % `GFX_PAL_ENTRIES), 2'b11);
    write_word(16'(`GFX_REG_BASE + REG_RECT_X), 16'($urandom % `GFX_H_VISIBLE), 2'b11);
    write_word(16'(`GFX_REG_BASE + REG_RECT_Y), 16'($urandom % `GFX_V_VISIBLE), 2'b11);
    write_word(16'(`GFX_REG_BASE + REG_RECT_W), 16'(1 + $urandom % 16), 2'b11);
    write_word(16'(`GFX_REG_BASE + REG_RECT_H), 16'(1 + $urandom % 12), 2'b11);
    write_word(16'(`GFX_REG_BASE + REG_CTRL), 16'h0001, 2'b11);
    wait_frame_end();
    check_frame();

    // Whole frame black with the display disabled
    write_word(16'(`GFX_REG_BASE + REG_CTRL), 16'h0000, 2'b11);
    wait_frame_end();
    check_frame();

    $display("No errors");
    $finish;
  end

endmodule

// File: rtl/gfx_core.sv
// Display controller top level
// Host bus and VGA output as plain ports around timing, host and renderer
`timescale 1ns/1ps
`include "gfx_cfg.svh"

module gfx_core (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mpu_en,
  input  logic                   mpu_rd,
  input  logic                   mpu_wr,
  input  logic [1:0]             mpu_be,
  input  logic [`GFX_ADDR_W-1:0] mpu_addr,
  input  logic [`GFX_DATA_W-1:0] mpu_wdata,
  output logic [`GFX_DATA_W-1:0] mpu_rdata,
  output logic                   vga_hsync,
  output logic                   vga_vsync,
  output logic [`GFX_RGB_W-1:0]  vga_rgb
);

  // Blank flags for the status register
  logic h_blank;
  logic v_blank;

  scan_if       scan ();
  render_cfg_if cfg ();

  display_timing i_display_timing (
    .clk     (clk),
    .rst     (rst),
    .scan    (scan.timing),
    .h_blank (h_blank),
    .v_blank (v_blank)
  );

  host_regs i_host_regs (
    .clk       (clk),
    .rst       (rst),
    .mpu_en    (mpu_en),
    .mpu_rd    (mpu_rd),
    .mpu_wr    (mpu_wr),
    .mpu_be    (mpu_be),
    .mpu_addr  (mpu_addr),
    .mpu_wdata (mpu_wdata),
    .mpu_rdata (mpu_rdata),
    .h_blank   (h_blank),
    .v_blank   (v_blank),
    .cfg       (cfg.host)
  );

  pixel_renderer i_pixel_renderer (
    .clk       (clk),
    .rst       (rst),
    .scan      (scan.render),
    .cfg       (cfg.render),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_rgb   (vga_rgb)
  );

endmodule

// File: rtl/pixel_renderer.sv
// Pixel renderer
// Rectangle test, palette lookup and two-stage sync alignment
`timescale 1ns/1ps
`include "gfx_cfg.svh"

module pixel_renderer (
  input  logic                  clk,
  input  logic                  rst,
  scan_if.render                scan,
  render_cfg_if.render          cfg,
  output logic                  vga_hsync,
  output logic                  vga_vsync,
  output logic [`GFX_RGB_W-1:0] vga_rgb
);

  logic [`GFX_DATA_W:0] x_pos;
  logic [`GFX_DATA_W:0] y_pos;
  logic [`GFX_DATA_W:0] x_end;
  logic [`GFX_DATA_W:0] y_end;
  logic                 in_rect;
  logic                 show_q;
  logic                 hsync_q;
  logic                 vsync_q;

  // Widen so rect_x + rect_w cannot wrap
  assign x_pos = {{(`GFX_DATA_W+1-`GFX_POS_W){1'b0}}, scan.hpos};
  assign y_pos = {{(`GFX_DATA_W+1-`GFX_POS_W){1'b0}}, scan.vpos};
  assign x_end = {1'b0, cfg.rect_x} + {1'b0, cfg.rect_w};
  assign y_end = {1'b0, cfg.rect_y} + {1'b0, cfg.rect_h};

  // Stage 1, end-exclusive rectangle on both axes
  assign in_rect = (x_pos >= {1'b0, cfg.rect_x}) && (x_pos < x_end) &&
                   (y_pos >= {1'b0, cfg.rect_y}) && (y_pos < y_end);

  assign cfg.pal_addr = in_rect ? cfg.rect_index : cfg.bg_index;

  always_ff @(posedge clk) begin
    if (rst) begin
      show_q    <= 1'b0;
      hsync_q   <= ~`GFX_SYNC_ACTIVE;
      vsync_q   <= ~`GFX_SYNC_ACTIVE;
      vga_hsync <= ~`GFX_SYNC_ACTIVE;
      vga_vsync <= ~`GFX_SYNC_ACTIVE;
      vga_rgb   <= '0;
    end else begin
      show_q    <= scan.visible && cfg.display_en;
      hsync_q   <= scan.hsync;
      vsync_q   <= scan.vsync;
      // Stage 2, palette colour is ready now
      vga_hsync <= hsync_q;
      vga_vsync <= vsync_q;
      vga_rgb   <= show_q ? cfg.pal_color : '0;
    end
  end

endmodule

// File: rtl/host_regs.sv
// Host access block
// Address decode, register file, palette RAM and registered read mux
`timescale 1ns/1ps
`include "gfx_cfg.svh"

module host_regs import gfx_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mpu_en,
  input  logic                   mpu_rd,
  input  logic                   mpu_wr,
  input  logic [1:0]             mpu_be,
  input  logic [`GFX_ADDR_W-1:0] mpu_addr,
  input  logic [`GFX_DATA_W-1:0] mpu_wdata,
  output logic [`GFX_DATA_W-1:0] mpu_rdata,
  input  logic                   h_blank,
  input  logic                   v_blank,
  render_cfg_if.host             cfg
);

  localparam int FIRST_RW = REG_CTRL;
  localparam int LAST_RW  = REG_RECT_INDEX;
  localparam int HI_W     = `GFX_RGB_W - `GFX_DATA_W;

  logic [`GFX_ADDR_W-1:0]    reg_off;
  logic [`GFX_ADDR_W-1:0]    pal_off;
  logic                      reg_sel;
  logic                      pal_sel;
  reg_index_e                reg_idx;
  logic                      reg_rw;
  logic [`GFX_PAL_IDX_W-1:0] pal_entry;
  logic [`GFX_DATA_W-1:0]    regs_q [FIRST_RW:LAST_RW];
  logic [`GFX_RGB_W-1:0]     pal_mem [`GFX_PAL_ENTRIES];
  logic [`GFX_RGB_W-1:0]     pal_word;
  logic [`GFX_RGB_W-1:0]     pal_color_q;
  logic [`GFX_DATA_W-1:0]    reg_rdata;
  logic [`GFX_DATA_W-1:0]    rdata;

  // Window decode, offsets wrap so one compare covers each window
  assign reg_off   = mpu_addr - `GFX_REG_BASE;
  assign pal_off   = mpu_addr - `GFX_PAL_BASE;
  assign reg_sel   = (reg_off < `GFX_NUM_REGS);
  assign pal_sel   = (pal_off < `GFX_PAL_WORDS);
  assign reg_idx   = reg_index_e'(reg_off[3:0]);
  assign reg_rw    = (int'(reg_idx) >= FIRST_RW) && (int'(reg_idx) <= LAST_RW);
  assign pal_entry = pal_off[`GFX_PAL_IDX_W:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = FIRST_RW; i <= LAST_RW; i++) begin
        regs_q[i] <= '0;
      end
    end else if (mpu_en && mpu_wr && reg_sel && reg_rw) begin
      if (mpu_be[0]) regs_q[reg_idx][7:0]  <= mpu_wdata[7:0];
      if (mpu_be[1]) regs_q[reg_idx][15:8] <= mpu_wdata[15:8];
    end
  end

  // Even words hold colour bits 15:0, odd words bits 17:16
  always_ff @(posedge clk) begin
    if (mpu_en && mpu_wr && pal_sel) begin
      if (!pal_off[0]) begin
        if (mpu_be[0]) pal_mem[pal_entry][7:0]  <= mpu_wdata[7:0];
        if (mpu_be[1]) pal_mem[pal_entry][15:8] <= mpu_wdata[15:8];
      end else if (mpu_be[0]) begin
        pal_mem[pal_entry][`GFX_RGB_W-1:`GFX_DATA_W] <= mpu_wdata[HI_W-1:0];
      end
    end
    // Renderer port
    pal_color_q <= pal_mem[cfg.pal_addr];
  end

  assign pal_word = pal_mem[pal_entry];

  always_comb begin
    case (reg_idx)
      REG_ID:     reg_rdata = `GFX_ID_VALUE;
      REG_STATUS: reg_rdata = {{(`GFX_DATA_W-2){1'b0}}, v_blank, h_blank};
      REG_CTRL, REG_BG_INDEX, REG_RECT_X, REG_RECT_Y,
      REG_RECT_W, REG_RECT_H, REG_RECT_INDEX:
                  reg_rdata = regs_q[reg_idx];
      default:    reg_rdata = '0;
    endcase
  end

  always_comb begin
    if (reg_sel) begin
      rdata = reg_rdata;
    end else if (pal_sel) begin
      rdata = pal_off[0] ? {{(`GFX_DATA_W-HI_W){1'b0}}, pal_word[`GFX_RGB_W-1:`GFX_DATA_W]}
                         : pal_word[`GFX_DATA_W-1:0];
    end else begin
      rdata = `GFX_UNMAPPED_VALUE;
    end
  end

  // Read data is held for one clock only, zero otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      mpu_rdata <= '0;
    end else begin
      mpu_rdata <= (mpu_en && mpu_rd) ? rdata : '0;
    end
  end

  assign cfg.display_en = regs_q[REG_CTRL][0];
  assign cfg.bg_index   = regs_q[REG_BG_INDEX][`GFX_PAL_IDX_W-1:0];
  assign cfg.rect_x     = regs_q[REG_RECT_X];
  assign cfg.rect_y     = regs_q[REG_RECT_Y];
  assign cfg.rect_w     = regs_q[REG_RECT_W];
  assign cfg.rect_h     = regs_q[REG_RECT_H];
  assign cfg.rect_index = regs_q[REG_RECT_INDEX][`GFX_PAL_IDX_W-1:0];
  assign cfg.pal_color  = pal_color_q;

endmodule

// File: rtl/display_timing.sv
// Display timing generator
// Horizontal and vertical counters with phase FSMs for sync and blank
`timescale 1ns/1ps
`include "gfx_cfg.svh"

module display_timing import gfx_pkg::*; (
  input  logic clk,
  input  logic rst,
  scan_if.timing scan,
  output logic h_blank,
  output logic v_blank
);

  localparam int H_TOTAL = `GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK;
  localparam int V_TOTAL = `GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK;

  logic [`GFX_POS_W-1:0] hpos_q;
  logic [`GFX_POS_W-1:0] vpos_q;
  scan_phase_e           h_phase;
  scan_phase_e           v_phase;
  logic                  h_last;
  logic                  v_last;

  // Phase steps on the last position of the current phase
  function automatic scan_phase_e next_phase(input scan_phase_e ph,
                                             input logic [`GFX_POS_W-1:0] pos,
                                             input int vis, input int front,
                                             input int sync, input int back);
    scan_phase_e nxt;
    nxt = ph;
    case (ph)
      PH_VISIBLE: if (int'(pos) == vis - 1) nxt = PH_FRONT;
      PH_FRONT:   if (int'(pos) == vis + front - 1) nxt = PH_SYNC;
      PH_SYNC:    if (int'(pos) == vis + front + sync - 1) nxt = PH_BACK;
      PH_BACK:    if (int'(pos) == vis + front + sync + back - 1) nxt = PH_VISIBLE;
      default:    nxt = PH_VISIBLE;
    endcase
    return nxt;
  endfunction

  assign h_last = (int'(hpos_q) == H_TOTAL - 1);
  assign v_last = (int'(vpos_q) == V_TOTAL - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      hpos_q  <= '0;
      vpos_q  <= '0;
      h_phase <= PH_VISIBLE;
      v_phase <= PH_VISIBLE;
    end else begin
      h_phase <= next_phase(h_phase, hpos_q, `GFX_H_VISIBLE, `GFX_H_FRONT,
                            `GFX_H_SYNC, `GFX_H_BACK);
      hpos_q  <= h_last ? '0 : hpos_q + 1'b1;
      // Vertical axis advances once per line
      if (h_last) begin
        v_phase <= next_phase(v_phase, vpos_q, `GFX_V_VISIBLE, `GFX_V_FRONT,
                              `GFX_V_SYNC, `GFX_V_BACK);
        vpos_q  <= v_last ? '0 : vpos_q + 1'b1;
      end
    end
  end

  assign scan.hpos    = hpos_q;
  assign scan.vpos    = vpos_q;
  assign scan.hsync   = (h_phase == PH_SYNC) ? `GFX_SYNC_ACTIVE : ~`GFX_SYNC_ACTIVE;
  assign scan.vsync   = (v_phase == PH_SYNC) ? `GFX_SYNC_ACTIVE : ~`GFX_SYNC_ACTIVE;
  assign scan.visible = (h_phase == PH_VISIBLE) && (v_phase == PH_VISIBLE);

  assign h_blank = (h_phase != PH_VISIBLE);
  assign v_blank = (v_phase != PH_VISIBLE);

endmodule

// File: rtl/render_cfg_if.sv
// Register values and palette read port
// Between the host block and the pixel renderer
`timescale 1ns/1ps
`include "gfx_cfg.svh"

interface render_cfg_if;

  logic                      display_en;
  logic [`GFX_PAL_IDX_W-1:0] bg_index;
  logic [`GFX_DATA_W-1:0]    rect_x;
  logic [`GFX_DATA_W-1:0]    rect_y;
  logic [`GFX_DATA_W-1:0]    rect_w;
  logic [`GFX_DATA_W-1:0]    rect_h;
  logic [`GFX_PAL_IDX_W-1:0] rect_index;

  // Synchronous palette read, colour follows address by one clock
  logic [`GFX_PAL_IDX_W-1:0] pal_addr;
  logic [`GFX_RGB_W-1:0]     pal_color;

  modport host (
    output display_en, bg_index, rect_x, rect_y, rect_w, rect_h, rect_index,
    output pal_color,
    input  pal_addr
  );

  modport render (
    input  display_en, bg_index, rect_x, rect_y, rect_w, rect_h, rect_index,
    input  pal_color,
    output pal_addr
  );

endinterface

// File: rtl/scan_if.sv
// Scan position and sync levels
// Driven by the timing generator, read by the renderer
`timescale 1ns/1ps
`include "gfx_cfg.svh"

interface scan_if;

  logic [`GFX_POS_W-1:0] hpos;
  logic [`GFX_POS_W-1:0] vpos;
  logic                  hsync;
  logic                  vsync;
  // High inside the 32x24 active area
  logic                  visible;

  modport timing (
    output hpos, vpos, hsync, vsync, visible
  );

  modport render (
    input hpos, vpos, hsync, vsync, visible
  );

endinterface

// File: rtl/gfx_pkg.sv
// Shared types of the display controller
// Register index enum and the scan phase enum

package gfx_pkg;

  // Main register window, one 16-bit word per index
  typedef enum logic [3:0] {
    REG_ID         = 4'd0,
    REG_CTRL       = 4'd1,   // bit 0 display enable
    REG_BG_INDEX   = 4'd2,
    REG_RECT_X     = 4'd3,
    REG_RECT_Y     = 4'd4,
    REG_RECT_W     = 4'd5,
    REG_RECT_H     = 4'd6,
    REG_RECT_INDEX = 4'd7,
    REG_STATUS     = 4'd8    // bit 0 h blank, bit 1 v blank
  } reg_index_e;

  // Phase of one scan axis, in scan order
  typedef enum logic [1:0] {
    PH_VISIBLE = 2'd0,
    PH_FRONT   = 2'd1,
    PH_SYNC    = 2'd2,
    PH_BACK    = 2'd3
  } scan_phase_e;

endpackage

// File: rtl/gfx_cfg.svh
// Configuration macros for the display controller
// Bus widths, raster timing, memory map and fixed register values
`ifndef GFX_CFG_SVH
`define GFX_CFG_SVH

// Host bus
`define GFX_ADDR_W          16
`define GFX_DATA_W          16

// Pixel colour and scan counters
`define GFX_RGB_W           18
`define GFX_POS_W           10

// Horizontal timing in clocks, 48 per line
`define GFX_H_VISIBLE       32
`define GFX_H_FRONT         4
`define GFX_H_SYNC          6
`define GFX_H_BACK          6

// Vertical timing in lines, 32 per frame
`define GFX_V_VISIBLE       24
`define GFX_V_FRONT         2
`define GFX_V_SYNC          2
`define GFX_V_BACK          4

// Syncs are active low
`define GFX_SYNC_ACTIVE     1'b0

// Memory map
`define GFX_REG_BASE        16'h0000
`define GFX_NUM_REGS        16
`define GFX_PAL_BASE        16'h0100
`define GFX_PAL_WORDS       256
`define GFX_PAL_ENTRIES     128
`define GFX_PAL_IDX_W       7

// Fixed read values
`define GFX_ID_VALUE        16'h6c43
`define GFX_UNMAPPED_VALUE  16'hdead

`define GFX_RENDER_LATENCY  2

`endif
